// ==== compile.f ====
hdl/cache_geom_pkg.sv
hdl/mem_bus_pkg.sv
hdl/cache_tag_array.sv
hdl/cache_data_array.sv
hdl/cache_fill_fsm.sv
hdl/cache_access_ctrl.sv
hdl/cache_top.sv
sim/mem_model.sv
sim/cache_assert.sv
sim/cache_tb.sv

// ==== hdl/cache_access_ctrl.sv ====
`default_nettype none

module cache_access_ctrl import cache_geom_pkg::*, mem_bus_pkg::*; (
    input wire clk,
    input wire rst_n,
    input wire cpu_rd,
    input wire cpu_wr,
    input wire cache_addr_t cpu_addr,
    input wire [data_w-1:0] cpu_wdata,
    output logic [data_w-1:0] cpu_rdata,
    output logic cpu_rdata_valid,
    output logic stall,
    input wire hit,                             // tag lookup of cpu_addr
    input wire [data_w-1:0] data_rdata,
    output logic tag_we,
    output logic [index_w-1:0] tag_index,
    output logic [tag_w-1:0] tag_value,
    output logic data_we,
    output logic [index_w-1:0] data_index,
    output logic [word_w-1:0] data_word,
    output logic [data_w-1:0] data_wdata,
    output logic fill_start,
    output logic [block_w-1:0] fill_block,
    input wire fill_rd,
    input wire [addr_w-1:0] fill_addr,
    input wire fill_we,
    input wire [word_w-1:0] fill_word,
    input wire [data_w-1:0] fill_data,
    input wire fill_done,
    input wire fill_busy,
    output logic mem_rd,
    output logic mem_wr,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata
);

    logic [1:0] state;                          // one of the access states from the package
    logic strobe;                               // an access is accepted this cycle
    logic rd_valid_q;                           // read data leaves the array next cycle
    cache_addr_t pend_addr;                     // access held across a miss or a write
    logic [data_w-1:0] pend_wdata;
    logic pend_wr;                              // the held access is a write

    assign strobe = (state == acc_idle) && (cpu_rd || cpu_wr);  // stall keeps strobes out otherwise
    assign stall = state != acc_idle;           // high from the cycle after a miss or write

    assign fill_start = strobe && !hit;
    assign fill_block = cpu_addr.blk.block;

    assign cpu_rdata = data_rdata;              // the array read is already registered
    assign cpu_rdata_valid = rd_valid_q;

    assign tag_we = fill_done;                  // the line turns valid with its last word
    assign tag_index = pend_addr.set.index;
    assign tag_value = pend_addr.set.tag;

    always_comb begin
        data_index = cpu_addr.set.index;        // a new strobe reads in its own cycle
        data_word = cpu_addr.set.word;
        data_wdata = pend_wdata;
        data_we = 1'b0;
        if (fill_busy) begin
            data_index = pend_addr.set.index;   // fill words go to the missed line
            data_word = fill_word;
            data_wdata = fill_data;
            data_we = fill_we;
        end else if (state != acc_idle) begin
            data_index = pend_addr.set.index;   // replay read or write-through commit
            data_word = pend_addr.set.word;
            data_we = state == acc_write;
        end
    end

    assign mem_rd = fill_rd;
    assign mem_wr = state == acc_write;         // memory and array take the write together
    assign mem_addr = fill_rd ? fill_addr : pend_addr;
    assign mem_wdata = pend_wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= acc_idle;
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= (strobe && cpu_rd && hit) || (state == acc_replay);
            case (state)
                acc_idle: begin
                    if (strobe && !hit) begin
                        state <= acc_fill;      // read and write misses both load the block
                    end else if (strobe && cpu_wr) begin
                        state <= acc_write;
                    end
                end
                acc_fill: begin
                    if (fill_done) begin
                        state <= pend_wr ? acc_write : acc_replay;
                    end
                end
                default: state <= acc_idle;     // replay and commit take one cycle each
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (strobe) begin
            pend_addr <= cpu_addr;
            pend_wdata <= cpu_wdata;
            pend_wr <= cpu_wr;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_data_array.sv ====
`default_nettype none

module cache_data_array import cache_geom_pkg::*, mem_bus_pkg::*; (
    input wire clk,
    input wire data_we,
    input wire [index_w-1:0] data_index,
    input wire [word_w-1:0] data_word,
    input wire [data_w-1:0] data_wdata,
    output logic [data_w-1:0] data_rdata        // valid one cycle after the address
);

    localparam int depth = num_lines * (2 ** word_w);   // words held by the cache

    logic [data_w-1:0] words [depth];           // line-major word storage
    logic [index_w+word_w-1:0] word_addr;       // flat word address into the storage

    assign word_addr = {data_index, data_word};

    always_ff @(posedge clk) begin
        if (data_we) begin
            words[word_addr] <= data_wdata;     // fill words and write-through data share this port
        end
        data_rdata <= words[word_addr];         // old contents on a same-cycle write
    end

endmodule

`default_nettype wire

// ==== hdl/cache_fill_fsm.sv ====
`default_nettype none

module cache_fill_fsm import cache_geom_pkg::*, mem_bus_pkg::*; (
    input wire clk,
    input wire rst_n,
    input wire fill_start,                      // one cycle pulse from the controller on a miss
    input wire [block_w-1:0] fill_block,        // block number that missed
    output logic fill_rd,                       // read request toward memory
    output logic [addr_w-1:0] fill_addr,
    output logic fill_we,                       // a returning word is ready for the data array
    output logic [word_w-1:0] fill_word,
    output logic [data_w-1:0] fill_data,
    output logic fill_done,                     // last word of the block is being written
    output logic fill_busy,
    input wire [data_w-1:0] mem_rdata,
    input wire mem_rdata_valid
);

    logic [1:0] state;                          // one of the fill states from the package
    logic [block_w-1:0] block_q;                // block being loaded
    logic [word_w-1:0] issue_cnt;               // next word to request
    logic [word_w-1:0] ret_cnt;                 // next word expected back
    logic [$clog2(mem_latency+1)-1:0] inflight; // reads sent that have not returned yet
    logic ret;                                  // a word of this fill arrives
    logic last_issue;
    logic last_ret;
    cache_addr_t issue_addr;                    // request address built in the block view

    always_comb begin
        issue_addr.blk.block = block_q;
        issue_addr.blk.word = issue_cnt;
        issue_addr.blk.byte_sel = 1'b0;         // word aligned
    end

    assign ret = mem_rdata_valid && (state != fill_idle);   // nothing else reads memory
    assign last_issue = issue_cnt == word_w'(words_per_block - 1);
    assign last_ret = ret_cnt == word_w'(words_per_block - 1);

    // a slot opens when a word comes back in the same cycle
    assign fill_rd = (state == fill_issue) && ((inflight < mem_latency) || ret);
    assign fill_addr = issue_addr;

    assign fill_we = ret;
    assign fill_word = ret_cnt;                 // returns come back in request order
    assign fill_data = mem_rdata;
    assign fill_done = ret && last_ret;
    assign fill_busy = state != fill_idle;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= fill_idle;
            issue_cnt <= '0;
            ret_cnt <= '0;
            inflight <= '0;
        end else begin
            case ({fill_rd, ret})
                2'b10: inflight <= inflight + 1'b1;     // one more read outstanding
                2'b01: inflight <= inflight - 1'b1;     // one read retired
                default: inflight <= inflight;          // both or neither keep the count
            endcase
            if (ret) begin
                ret_cnt <= ret_cnt + 1'b1;              // wraps to zero after the last word
            end
            case (state)
                fill_idle: begin
                    if (fill_start) begin
                        state <= fill_issue;
                        issue_cnt <= '0;
                        ret_cnt <= '0;
                    end
                end
                fill_issue: begin
                    if (fill_rd) begin
                        issue_cnt <= issue_cnt + 1'b1;
                        if (last_issue) begin
                            state <= fill_drain;        // the remaining words are in flight
                        end
                    end
                end
                fill_drain: begin
                    if (fill_done) begin
                        state <= fill_idle;
                    end
                end
                default: state <= fill_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == fill_idle) && fill_start) begin
            block_q <= fill_block;              // held for all eight requests
        end
    end

endmodule

`default_nettype wire

// ==== hdl/cache_geom_pkg.sv ====
`default_nettype none

package cache_geom_pkg;

    localparam int addr_w = 16;                 // processor and memory byte address
    localparam int tag_w = 5;                   // upper address bits stored per line
    localparam int index_w = 7;                 // selects one of the cache lines
    localparam int word_w = 3;                  // word within a 16 byte block
    localparam int num_lines = 128;             // 2 KB split into 16 byte lines
    localparam int block_w = tag_w + index_w;   // block number as the memory sees it

    // the access controller walks through these states on every access
    localparam logic [1:0] acc_idle = 2'd0;     // accepting new strobes
    localparam logic [1:0] acc_fill = 2'd1;     // the fill engine is loading the block
    localparam logic [1:0] acc_replay = 2'd2;   // the missed read is issued again
    localparam logic [1:0] acc_write = 2'd3;    // write-through commit to array and memory

    // one address word with two decodings
    typedef union packed {
        struct packed {
            logic [tag_w-1:0] tag;              // compared against the stored tag
            logic [index_w-1:0] index;          // line select
            logic [word_w-1:0] word;            // word select inside the line
            logic byte_sel;                     // ignored since every access is a full word
        } set;
        struct packed {
            logic [block_w-1:0] block;          // tag and index taken together
            logic [word_w-1:0] word;            // same bits as the set view word
            logic byte_sel;                     // ignored here as well
        } blk;
    } cache_addr_t;

endpackage

`default_nettype wire

// ==== hdl/cache_tag_array.sv ====
`default_nettype none

module cache_tag_array import cache_geom_pkg::*; (
    input wire clk,
    input wire rst_n,
    input wire cache_addr_t lookup_addr,        // address of the strobe being looked up
    input wire tag_we,                          // pulses once the block is fully loaded
    input wire [index_w-1:0] tag_index,
    input wire [tag_w-1:0] tag_value,
    output logic hit
);

    logic [num_lines-1:0] valid;                // one valid bit per line
    logic [tag_w-1:0] tags [num_lines];         // stored tag per line
    logic [index_w-1:0] look_index;             // line picked by the lookup address

    assign look_index = lookup_addr.set.index;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= '0;                        // every line starts empty
        end else if (tag_we) begin
            valid[tag_index] <= 1'b1;           // the line now holds a whole block
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[tag_index] <= tag_value;       // replaces whatever block lived here before
        end
    end

    // purely combinational so a hit is known in the strobe cycle
    assign hit = valid[look_index] && (tags[look_index] == lookup_addr.set.tag);

endmodule

`default_nettype wire

// ==== hdl/cache_top.sv ====
`default_nettype none

module cache_top import cache_geom_pkg::*, mem_bus_pkg::*; (
    input wire clk,
    input wire rst_n,
    input wire cpu_rd,
    input wire cpu_wr,
    input wire cache_addr_t cpu_addr,
    input wire [data_w-1:0] cpu_wdata,
    output logic [data_w-1:0] cpu_rdata,
    output logic cpu_rdata_valid,
    output logic stall,
    output logic mem_rd,
    output logic mem_wr,
    output logic [addr_w-1:0] mem_addr,
    output logic [data_w-1:0] mem_wdata,
    input wire [data_w-1:0] mem_rdata,
    input wire mem_rdata_valid
);

    logic hit;                                  // lookup result for cpu_addr
    logic [data_w-1:0] data_rdata;
    logic tag_we;
    logic [index_w-1:0] tag_index;
    logic [tag_w-1:0] tag_value;
    logic data_we;
    logic [index_w-1:0] data_index;
    logic [word_w-1:0] data_word;
    logic [data_w-1:0] data_wdata;
    logic fill_start;
    logic [block_w-1:0] fill_block;
    logic fill_rd;
    logic [addr_w-1:0] fill_addr;
    logic fill_we;
    logic [word_w-1:0] fill_word;
    logic [data_w-1:0] fill_data;
    logic fill_done;
    logic fill_busy;

    cache_tag_array u_tags (
        .clk(clk), .rst_n(rst_n), .lookup_addr(cpu_addr),
        .tag_we(tag_we), .tag_index(tag_index), .tag_value(tag_value), .hit(hit)
    );

    cache_data_array u_data (
        .clk(clk), .data_we(data_we), .data_index(data_index), .data_word(data_word),
        .data_wdata(data_wdata), .data_rdata(data_rdata)
    );

    cache_fill_fsm u_fill (
        .clk(clk), .rst_n(rst_n), .fill_start(fill_start), .fill_block(fill_block),
        .fill_rd(fill_rd), .fill_addr(fill_addr), .fill_we(fill_we), .fill_word(fill_word),
        .fill_data(fill_data), .fill_done(fill_done), .fill_busy(fill_busy),
        .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
    );

    cache_access_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
        .cpu_rdata(cpu_rdata), .cpu_rdata_valid(cpu_rdata_valid), .stall(stall),
        .hit(hit), .data_rdata(data_rdata),
        .tag_we(tag_we), .tag_index(tag_index), .tag_value(tag_value),
        .data_we(data_we), .data_index(data_index), .data_word(data_word),
        .data_wdata(data_wdata),
        .fill_start(fill_start), .fill_block(fill_block),
        .fill_rd(fill_rd), .fill_addr(fill_addr), .fill_we(fill_we), .fill_word(fill_word),
        .fill_data(fill_data), .fill_done(fill_done), .fill_busy(fill_busy),
        .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

// ==== hdl/mem_bus_pkg.sv ====
`default_nettype none

package mem_bus_pkg;

    localparam int data_w = 16;                 // one memory word per transfer
    localparam int words_per_block = 8;         // transfers needed to fill one line
    localparam int mem_latency = 4;             // cycles from mem_rd to its returning data

    // fill engine states
    localparam logic [1:0] fill_idle = 2'd0;    // no miss being serviced
    localparam logic [1:0] fill_issue = 2'd1;   // sending one read per cycle
    localparam logic [1:0] fill_drain = 2'd2;   // all reads sent, collecting the rest

endpackage

`default_nettype wire

// ==== sim/cache_assert.sv ====
`default_nettype none

module cache_assert (
    input wire clk,
    input wire rst_n,
    input wire cpu_rd,
    input wire cpu_wr,
    input wire stall,
    input wire cpu_rdata_valid,
    input wire mem_rd,
    input wire mem_wr
);
    timeunit 1ns;
    timeprecision 1ps;

    // the memory port carries either a fill read or a write-through, never both
    mem_port_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rd && mem_wr))
        else $error("mem_rd and mem_wr are high in the same cycle");

    strobe_only_unstalled: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_rd || cpu_wr) |-> !stall)         // the processor must hold off while stalled
        else $error("processor strobe arrived while stall was high");

    rdata_valid_unstalled: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(cpu_rdata_valid) |-> !stall)     // a replayed read ends the stall in that cycle
        else $error("cpu_rdata_valid rose while stall was high");

endmodule

`default_nettype wire

// ==== sim/cache_tb.sv ====
`default_nettype none

module cache_tb import cache_geom_pkg::*, mem_bus_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic wr;                               // 1 for a write, 0 for a read
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
        logic miss;                             // known from the order of the table
        logic [data_w-1:0] rdata;               // memory rule value or the last write
    } test_t;

    logic clk, rst_n, cpu_rd, cpu_wr, stall, cpu_rdata_valid, mem_rd, mem_wr, mem_rdata_valid;
    cache_addr_t cpu_addr;
    logic [data_w-1:0] cpu_wdata, cpu_rdata, mem_wdata, mem_rdata;
    logic [addr_w-1:0] mem_addr, fill_base, wr_addr_seen;
    logic [data_w-1:0] wr_data_seen;
    logic [data_w-1:0] shadow [int];            // words written so far, keyed by word number
    test_t tests [$];
    int errors = 0, passed = 0, cycles = 0;
    int rd_count, wr_count, first_rd, last_rd;  // memory traffic seen during one test

    cache_top UUT (
        .clk(clk), .rst_n(rst_n), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .cpu_addr(cpu_addr),
        .cpu_wdata(cpu_wdata), .cpu_rdata(cpu_rdata), .cpu_rdata_valid(cpu_rdata_valid),
        .stall(stall), .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
    );

    mem_model u_mem (
        .clk(clk), .rst_n(rst_n), .mem_rd(mem_rd), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
    );

    bind cache_top cache_assert u_assert (
        .clk(clk), .rst_n(rst_n), .cpu_rd(cpu_rd), .cpu_wr(cpu_wr), .stall(stall),
        .cpu_rdata_valid(cpu_rdata_valid), .mem_rd(mem_rd), .mem_wr(mem_wr)
    );

    always #10 clk = ~clk;                      // 20 ns period

    function automatic void add_test(logic wr, logic [addr_w-1:0] addr,
                                     logic [data_w-1:0] wdata, logic miss);
        test_t t;
        int w;
        logic [data_w-1:0] expected;
        w = addr[addr_w-1:1];                   // word number inside the memory
        expected = shadow.exists(w) ? shadow[w] : data_w'(w) ^ 16'h5a5a;
        if (wr) begin
            shadow[w] = wdata;                  // later reads of this word expect the new value
        end
        t = '{wr, addr, wdata, miss, expected};
        tests.push_back(t);
    endfunction

    task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
        $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        errors++;
    endtask

    // memory traffic is sampled on the rising edge, away from the falling-edge drive
    always @(posedge clk) begin
        cycles++;
        if (mem_rd) begin
            if (mem_addr != fill_base + addr_w'(rd_count * 2))
                report_value("mem_addr", mem_addr, fill_base + addr_w'(rd_count * 2));
            if (rd_count == 0)
                first_rd = cycles;
            last_rd = cycles;
            rd_count++;
        end
        if (mem_wr) begin
            wr_count++;
            wr_addr_seen = mem_addr;
            wr_data_seen = mem_wdata;
        end
        if (cycles >= tests.size() * 20) begin
            $display("timeout: the cache did not finish the tests in %0d cycles", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic run_test(input int n);
        test_t t;
        logic stall_first, valid_first;
        int errs_before;
        t = tests[n];
        errs_before = errors;
        rd_count = 0;
        wr_count = 0;
        fill_base = {t.addr[addr_w-1:word_w+1], {(word_w + 1){1'b0}}};  // first word of block
        cpu_rd = !t.wr;
        cpu_wr = t.wr;
        cpu_addr = t.addr;
        cpu_wdata = t.wdata;
        @(negedge clk);
        cpu_rd = 1'b0;                          // strobes last a single cycle
        cpu_wr = 1'b0;
        stall_first = stall;
        valid_first = cpu_rdata_valid;
        if (t.wr) begin
            while (stall) @(negedge clk);       // the write-through ends the stall
        end else begin
            while (!cpu_rdata_valid) @(negedge clk);
            if (cpu_rdata != t.rdata) report_value("cpu_rdata", cpu_rdata, t.rdata);
            if (stall) report_value("stall", stall, 1'b0);
            if (wr_count != 0) begin
                $display("a read sent a write to memory at %0d ns", $time);
                errors++;
            end
        end
        if ((rd_count != 0) != t.miss) report_value("miss", rd_count != 0, t.miss);
        if (t.miss && !stall_first) begin
            $display("stall did not rise after a missing strobe at %0d ns", $time);
            errors++;
        end
        if (t.miss && (rd_count != words_per_block || last_rd - first_rd != 7)) begin
            $display("fill did not issue 8 reads in consecutive cycles (%0d seen)", rd_count);
            errors++;
        end
        if (!t.miss && !t.wr && (stall_first || !valid_first)) begin
            $display("read hit did not return data one cycle after its strobe");
            errors++;
        end
        if (t.wr && wr_count != 1) begin
            $display("write sent %0d writes to memory instead of one", wr_count);
            errors++;
        end
        if (t.wr && wr_addr_seen != t.addr) report_value("mem_addr", wr_addr_seen, t.addr);
        if (t.wr && wr_data_seen != t.wdata) report_value("mem_wdata", wr_data_seen, t.wdata);
        if (errors == errs_before)
            passed++;
        $display("test %0d %s %h miss=%0d: %s", n, t.wr ? "write" : "read", t.addr,
                 rd_count != 0, errors == errs_before ? "ok" : "mismatch");
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        cpu_rd = 1'b0;
        cpu_wr = 1'b0;
        cpu_addr = '0;
        cpu_wdata = '0;
        add_test(1'b0, 16'h1234, 16'h0000, 1'b1);   // cold read fills tag 2, index 0x23
        add_test(1'b0, 16'h123a, 16'h0000, 1'b0);   // other word of the same block
        add_test(1'b1, 16'h1236, 16'hbeef, 1'b0);   // write hit goes through to memory
        add_test(1'b0, 16'h1236, 16'h0000, 1'b0);
        add_test(1'b1, 16'h4562, 16'hc0de, 1'b1);   // write miss loads the block first
        add_test(1'b0, 16'h4560, 16'h0000, 1'b0);   // neighbours keep the memory values
        add_test(1'b0, 16'h4564, 16'h0000, 1'b0);
        add_test(1'b0, 16'h4562, 16'h0000, 1'b0);
        add_test(1'b0, 16'h9234, 16'h0000, 1'b1);   // same index with tag 18 evicts the line
        add_test(1'b0, 16'h1236, 16'h0000, 1'b1);   // back to tag 2 misses again
        add_test(1'b0, 16'h9230, 16'h0000, 1'b1);
        add_test(1'b0, 16'h123e, 16'h0000, 1'b1);
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        foreach (tests[i]) run_test(i);
        $display("%0d tests, %0d passed, %0d errors", tests.size(), passed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/mem_model.sv ====
`default_nettype none

module mem_model import cache_geom_pkg::*, mem_bus_pkg::*; (
    input wire clk,
    input wire rst_n,
    input wire mem_rd,                          // one read request per cycle at most
    input wire mem_wr,
    input wire [addr_w-1:0] mem_addr,           // byte address, bit 0 is ignored
    input wire [data_w-1:0] mem_wdata,
    output logic [data_w-1:0] mem_rdata,
    output logic mem_rdata_valid                // pulses mem_latency cycles after mem_rd
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [data_w-1:0] words [2 ** (addr_w - 1)];   // 64 KB held as 32K words
    logic [mem_latency-1:0] vld_pipe;           // one stage per cycle of latency
    logic [data_w-1:0] dat_pipe [mem_latency];  // read data moves along with its valid bit

    initial begin
        for (int i = 0; i < 2 ** (addr_w - 1); i++) begin
            words[i] = data_w'(i) ^ 16'h5a5a;   // every word starts from its word number
        end
    end

    always @(posedge clk) begin
        if (mem_wr) begin
            words[mem_addr[addr_w-1:1]] <= mem_wdata;   // writes land in a single cycle
        end
        dat_pipe[0] <= words[mem_addr[addr_w-1:1]];
        for (int i = 1; i < mem_latency; i++) begin
            dat_pipe[i] <= dat_pipe[i-1];
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_pipe <= '0;                     // nothing in flight after reset
        end else begin
            vld_pipe <= {vld_pipe[mem_latency-2:0], mem_rd};
        end
    end

    assign mem_rdata_valid = vld_pipe[mem_latency-1];
    assign mem_rdata = dat_pipe[mem_latency-1];

endmodule

`default_nettype wire
